/* build.f */
+incdir+common
common/ndn_pkg.sv
hw/spi_rx_deframer.sv
hw/spi_tx_framer.sv
fib_table/fib_table.sv
hw/ndn_face_top.sv
tb/tb_clk_gen.sv
tb/tb_ndn_face.sv

/* common/ndn_cfg.svh */
`ifndef NDN_CFG_SVH
`define NDN_CFG_SVH

// Name prefix width in bits, also the exact-match key of the table
`define NDN_PREFIX_W 64

// Prefix length in bytes on the serial link
`define NDN_PREFIX_BYTES (`NDN_PREFIX_W / 8)

// Payload carried by a data packet
`define NDN_PAYLOAD_BYTES 8
`define NDN_PAYLOAD_W (`NDN_PAYLOAD_BYTES * 8)

// Bytes on the wire, metadata byte plus prefix, plus payload for data
`define NDN_INTEREST_BYTES (1 + `NDN_PREFIX_BYTES)
`define NDN_DATA_BYTES (`NDN_INTEREST_BYTES + `NDN_PAYLOAD_BYTES)

// Learned-prefix entries, a power of two
`define NDN_FIB_DEPTH 4

`endif

/* common/ndn_pkg.sv */
`include "ndn_cfg.svh"

package ndn_pkg;

    // Metadata byte codes that open a packet on the link
    typedef enum logic [7:0] {
        kind_interest = 8'h70,
        kind_data     = 8'h30
    } pkt_kind_e;

    // One packet as it travels between deframer, table and framer
    typedef struct packed {
        pkt_kind_e                   kind;
        logic [`NDN_PREFIX_W-1:0]    prefix;
        logic [`NDN_PAYLOAD_W-1:0]   payload;
    } ndn_pkt_t;

    // Learned prefix slot of the forwarding table
    typedef struct packed {
        logic                        used;
        logic [`NDN_PREFIX_W-1:0]    prefix;
    } fib_entry_t;

    // Deframer states
    typedef enum logic [1:0] {
        rx_meta,
        rx_prefix,
        rx_payload,
        rx_hold
    } rx_state_e;

    // Framer states
    typedef enum logic {
        tx_idle,
        tx_send
    } tx_state_e;

endpackage

/* fib_table/fib_table.sv */
`include "ndn_cfg.svh"

module fib_table (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  ndn_pkg::ndn_pkt_t   in_pkt,
    output logic                in_ready,
    output logic                pit_out_valid,
    output ndn_pkg::ndn_pkt_t   pit_out_pkt,
    input  logic                pit_out_ready,
    input  logic                pit_in_valid,
    input  ndn_pkg::ndn_pkt_t   pit_in_pkt,
    output logic                pit_in_ready,
    output logic                out_valid,
    output ndn_pkg::ndn_pkt_t   out_pkt,
    input  logic                out_ready,
    output logic [7:0]          drop_count
);

    localparam int DEPTH = `NDN_FIB_DEPTH;
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    ndn_pkg::fib_entry_t tbl [DEPTH];
    logic [IDX_W-1:0]    rr_ptr;

    logic             in_fire;
    logic             in_is_data;
    logic             hit;
    logic [IDX_W-1:0] hit_idx;
    logic             remove;
    logic             deliver;
    logic             drop;

    logic             pit_in_fire;
    logic             learn;
    logic [DEPTH-1:0] used_after;
    logic             dup;
    logic             free;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] ins_idx;

    // Each output register accepts when empty or draining this cycle
    assign in_ready     = !pit_out_valid || pit_out_ready;
    assign pit_in_ready = !out_valid || out_ready;
    assign in_fire      = in_valid && in_ready;
    assign pit_in_fire  = pit_in_valid && pit_in_ready;

    assign in_is_data = (in_pkt.kind == ndn_pkg::kind_data);
    assign remove     = in_fire && in_is_data && hit;
    assign deliver    = in_fire && (!in_is_data || hit);
    assign drop       = in_fire && in_is_data && !hit;
    assign learn      = pit_in_fire && (pit_in_pkt.kind == ndn_pkg::kind_interest);
    assign ins_idx    = free ? free_idx : rr_ptr;

    // Exact-prefix lookup for incoming data, first match wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!hit && tbl[i].used && (tbl[i].prefix == in_pkt.prefix)) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    // Insert decisions see the table with this cycle's removal applied
    always_comb begin
        dup      = 1'b0;
        free     = 1'b0;
        free_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            used_after[i] = tbl[i].used && !(remove && (hit_idx == IDX_W'(i)));
            if (used_after[i] && (tbl[i].prefix == pit_in_pkt.prefix)) begin
                dup = 1'b1;
            end
            if (!free && !used_after[i]) begin
                free     = 1'b1;
                free_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                tbl[i] <= '0;
            end
            rr_ptr <= '0;
        end else begin
            if (remove) begin
                tbl[hit_idx].used <= 1'b0;
            end
            // Later write wins, so a same-cycle insert lands after the removal
            if (learn && !dup) begin
                tbl[ins_idx].used   <= 1'b1;
                tbl[ins_idx].prefix <= pit_in_pkt.prefix;
                if (!free) begin
                    rr_ptr <= rr_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pit_out_valid <= 1'b0;
            out_valid     <= 1'b0;
            drop_count    <= '0;
        end else begin
            if (deliver) begin
                pit_out_valid <= 1'b1;
            end else if (pit_out_ready) begin
                pit_out_valid <= 1'b0;
            end
            if (pit_in_fire) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            if (drop) begin
                drop_count <= drop_count + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deliver) begin
            pit_out_pkt <= in_pkt;
        end
        if (pit_in_fire) begin
            out_pkt <= pit_in_pkt;
        end
    end

endmodule

/* hw/ndn_face_top.sv */
module ndn_face_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rx_valid,
    input  logic [7:0]          rx_data,
    output logic                rx_ready,
    output logic                tx_valid,
    output logic [7:0]          tx_data,
    input  logic                tx_ready,
    input  logic                pit_in_valid,
    input  ndn_pkg::ndn_pkt_t   pit_in_pkt,
    output logic                pit_in_ready,
    output logic                pit_out_valid,
    output ndn_pkg::ndn_pkt_t   pit_out_pkt,
    input  logic                pit_out_ready,
    output logic [7:0]          drop_count
);

    logic              rxp_valid;
    ndn_pkg::ndn_pkt_t rxp_pkt;
    logic              rxp_ready;
    logic              txp_valid;
    ndn_pkg::ndn_pkt_t txp_pkt;
    logic              txp_ready;

    spi_rx_deframer spi_rx_deframer_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready),
        .pkt_valid (rxp_valid),
        .pkt       (rxp_pkt),
        .pkt_ready (rxp_ready)
    );

    // Incoming packets go to the PIT, PIT packets head for the link
    fib_table fib_table_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (rxp_valid),
        .in_pkt        (rxp_pkt),
        .in_ready      (rxp_ready),
        .pit_out_valid (pit_out_valid),
        .pit_out_pkt   (pit_out_pkt),
        .pit_out_ready (pit_out_ready),
        .pit_in_valid  (pit_in_valid),
        .pit_in_pkt    (pit_in_pkt),
        .pit_in_ready  (pit_in_ready),
        .out_valid     (txp_valid),
        .out_pkt       (txp_pkt),
        .out_ready     (txp_ready),
        .drop_count    (drop_count)
    );

    spi_tx_framer spi_tx_framer_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .pkt_valid (txp_valid),
        .pkt       (txp_pkt),
        .pkt_ready (txp_ready),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready)
    );

endmodule

/* hw/spi_rx_deframer.sv */
`include "ndn_cfg.svh"

module spi_rx_deframer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rx_valid,
    input  logic [7:0]          rx_data,
    output logic                rx_ready,
    output logic                pkt_valid,
    output ndn_pkg::ndn_pkt_t   pkt,
    input  logic                pkt_ready
);

    localparam int MAX_BYTES = (`NDN_PREFIX_BYTES > `NDN_PAYLOAD_BYTES) ?
                               `NDN_PREFIX_BYTES : `NDN_PAYLOAD_BYTES;
    localparam int CNT_W = (MAX_BYTES > 1) ? $clog2(MAX_BYTES) : 1;

    ndn_pkg::rx_state_e state;
    logic [CNT_W-1:0]   cnt;
    logic               rx_fire;
    logic               is_kind;

    assign rx_ready  = (state != ndn_pkg::rx_hold);
    assign pkt_valid = (state == ndn_pkg::rx_hold);
    assign rx_fire   = rx_valid && rx_ready;

    // Only the two metadata codes may start a packet
    assign is_kind = (rx_data == ndn_pkg::kind_interest) || (rx_data == ndn_pkg::kind_data);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ndn_pkg::rx_meta;
            cnt   <= '0;
        end else begin
            case (state)
                ndn_pkg::rx_meta: begin
                    if (rx_fire && is_kind) begin
                        cnt   <= '0;
                        state <= ndn_pkg::rx_prefix;
                    end
                end
                ndn_pkg::rx_prefix: begin
                    if (rx_fire) begin
                        if (cnt == CNT_W'(`NDN_PREFIX_BYTES - 1)) begin
                            cnt <= '0;
                            if (pkt.kind == ndn_pkg::kind_data) begin
                                state <= ndn_pkg::rx_payload;
                            end else begin
                                state <= ndn_pkg::rx_hold;
                            end
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                ndn_pkg::rx_payload: begin
                    if (rx_fire) begin
                        if (cnt == CNT_W'(`NDN_PAYLOAD_BYTES - 1)) begin
                            cnt   <= '0;
                            state <= ndn_pkg::rx_hold;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (pkt_ready) begin
                        state <= ndn_pkg::rx_meta;
                    end
                end
            endcase
        end
    end

    // Packet fields shift in MSB first; an interest keeps its cleared payload
    always_ff @(posedge clk) begin
        if (rx_fire) begin
            case (state)
                ndn_pkg::rx_meta: begin
                    if (is_kind) begin
                        pkt.kind    <= ndn_pkg::pkt_kind_e'(rx_data);
                        pkt.payload <= '0;
                    end
                end
                ndn_pkg::rx_prefix: pkt.prefix <= {pkt.prefix[`NDN_PREFIX_W-9:0], rx_data};
                ndn_pkg::rx_payload: pkt.payload <= {pkt.payload[`NDN_PAYLOAD_W-9:0], rx_data};
                default: ;
            endcase
        end
    end

endmodule

/* hw/spi_tx_framer.sv */
`include "ndn_cfg.svh"

module spi_tx_framer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pkt_valid,
    input  ndn_pkg::ndn_pkt_t   pkt,
    output logic                pkt_ready,
    output logic                tx_valid,
    output logic [7:0]          tx_data,
    input  logic                tx_ready
);

    localparam int PKT_W = $bits(ndn_pkg::ndn_pkt_t);
    localparam int CNT_W = $clog2(`NDN_DATA_BYTES);

    ndn_pkg::tx_state_e state;
    logic [PKT_W-1:0]   shreg;
    logic [CNT_W-1:0]   cnt;
    logic [CNT_W-1:0]   last_idx;
    logic               is_data;
    logic               pkt_fire;
    logic               tx_fire;

    assign pkt_ready = (state == ndn_pkg::tx_idle);
    assign tx_valid  = (state == ndn_pkg::tx_send);
    assign pkt_fire  = pkt_valid && pkt_ready;
    assign tx_fire   = tx_valid && tx_ready;

    // Kind byte sits on top of the struct, so the MSB byte goes out first
    assign tx_data = shreg[PKT_W-1 -: 8];

    // Interests stop after the prefix, data runs through the payload
    assign last_idx = is_data ? CNT_W'(`NDN_DATA_BYTES - 1) : CNT_W'(`NDN_INTEREST_BYTES - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ndn_pkg::tx_idle;
            cnt     <= '0;
            is_data <= 1'b0;
        end else begin
            case (state)
                ndn_pkg::tx_idle: begin
                    if (pkt_fire) begin
                        is_data <= (pkt.kind == ndn_pkg::kind_data);
                        cnt     <= '0;
                        state   <= ndn_pkg::tx_send;
                    end
                end
                default: begin
                    if (tx_fire) begin
                        if (cnt == last_idx) begin
                            state <= ndn_pkg::tx_idle;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_fire) begin
            shreg <= pkt;
        end else if (tx_fire) begin
            shreg <= {shreg[PKT_W-9:0], 8'h00};
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f build.f --top-module tb_ndn_face -o sim_ndn_face

./obj_dir/sim_ndn_face 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "Simulation ended without a pass result"
    exit 1
fi
echo "Simulation passed"

/* tb/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk
);

    // Period of 4 time units
    localparam int HALF_PERIOD = 2;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

/* tb/tb_ndn_face.sv */
`include "ndn_cfg.svh"

module tb_ndn_face;

    localparam int NUM_ROWS       = 15;
    localparam int TIMEOUT_CYCLES = 60 * NUM_ROWS;
    localparam int CMP_W          = $bits(ndn_pkg::ndn_pkt_t);

    typedef enum logic {op_rx, op_pit} op_e;
    typedef enum logic [1:0] {res_deliver, res_drop, res_tx} res_e;

    // One stimulus row with the count of non-metadata bytes to send before the packet
    typedef struct packed {
        op_e               op;
        ndn_pkg::ndn_pkt_t pkt;
        res_e              res;
        logic [1:0]        junk;
    } row_t;

    logic              clk;
    logic              arst_n;
    logic              rx_valid;
    logic [7:0]        rx_data;
    logic              rx_ready;
    logic              tx_valid;
    logic [7:0]        tx_data;
    logic              tx_ready;
    logic              pit_in_valid;
    ndn_pkg::ndn_pkt_t pit_in_pkt;
    logic              pit_in_ready;
    logic              pit_out_valid;
    ndn_pkg::ndn_pkt_t pit_out_pkt;
    logic              pit_out_ready;
    logic [7:0]        drop_count;

    row_t              rows [NUM_ROWS];
    logic [7:0]        junk_bytes [3];
    ndn_pkg::ndn_pkt_t pit_q [$];
    logic [7:0]        tx_q [$];
    logic [7:0]        drops;
    integer            seed;
    integer            rnd;
    int                cycles = 0;

    tb_clk_gen clk_gen_i (
        .clk (clk)
    );

    ndn_face_top ndn_face_top_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .rx_valid      (rx_valid),
        .rx_data       (rx_data),
        .rx_ready      (rx_ready),
        .tx_valid      (tx_valid),
        .tx_data       (tx_data),
        .tx_ready      (tx_ready),
        .pit_in_valid  (pit_in_valid),
        .pit_in_pkt    (pit_in_pkt),
        .pit_in_ready  (pit_in_ready),
        .pit_out_valid (pit_out_valid),
        .pit_out_pkt   (pit_out_pkt),
        .pit_out_ready (pit_out_ready),
        .drop_count    (drop_count)
    );

    task automatic abort_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [CMP_W-1:0] got,
                               input logic [CMP_W-1:0] want);
        if (got !== want) begin
            $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
            abort_run();
        end
    endtask

    // Link order is the metadata byte, then prefix and payload MSB first
    function automatic logic [7:0] wire_byte(input ndn_pkg::ndn_pkt_t p, input int idx);
        if (idx == 0) begin
            return p.kind;
        end else if (idx <= `NDN_PREFIX_BYTES) begin
            return p.prefix[(`NDN_PREFIX_BYTES - idx) * 8 +: 8];
        end
        return p.payload[(`NDN_DATA_BYTES - 1 - idx) * 8 +: 8];
    endfunction

    function automatic int wire_len(input ndn_pkg::pkt_kind_e kind);
        return (kind == ndn_pkg::kind_data) ? `NDN_DATA_BYTES : `NDN_INTEREST_BYTES;
    endfunction

    function automatic row_t make_row(input op_e op, input ndn_pkg::pkt_kind_e kind,
                                      input logic [`NDN_PREFIX_W-1:0] prefix,
                                      input logic [`NDN_PAYLOAD_W-1:0] payload,
                                      input res_e res, input logic [1:0] junk);
        row_t r;
        r.op          = op;
        r.pkt.kind    = kind;
        r.pkt.prefix  = prefix;
        r.pkt.payload = payload;
        r.res         = res;
        r.junk        = junk;
        return r;
    endfunction

    task automatic load_rows();
        // Payload of an rx interest never goes on the wire
        rows[0]  = make_row(op_rx, ndn_pkg::kind_interest, 64'h0011_2233_4455_6677,
                            64'hffff_0000_ffff_0000, res_deliver, 2'd0);
        rows[1]  = make_row(op_rx, ndn_pkg::kind_data, 64'h8899_aabb_ccdd_eeff,
                            64'h0102_0304_0506_0708, res_drop, 2'd0);
        rows[2]  = make_row(op_pit, ndn_pkg::kind_interest, 64'hc0de_0001_c0de_0002,
                            64'h0, res_tx, 2'd0);
        rows[3]  = make_row(op_rx, ndn_pkg::kind_data, 64'hc0de_0001_c0de_0002,
                            64'hdead_beef_0123_4567, res_deliver, 2'd0);
        rows[4]  = make_row(op_rx, ndn_pkg::kind_data, 64'hc0de_0001_c0de_0002,
                            64'hdead_beef_0123_4567, res_drop, 2'd0);
        rows[5]  = make_row(op_pit, ndn_pkg::kind_data, 64'h7030_7030_7030_7030,
                            64'hfedc_ba98_7654_3210, res_tx, 2'd0);
        rows[6]  = make_row(op_rx, ndn_pkg::kind_interest, 64'h1357_9bdf_2468_ace0,
                            64'h0, res_deliver, 2'd3);
        rows[7]  = make_row(op_pit, ndn_pkg::kind_interest, 64'h1111_0000_0000_0001,
                            64'h0, res_tx, 2'd0);
        rows[8]  = make_row(op_pit, ndn_pkg::kind_interest, 64'h2222_0000_0000_0002,
                            64'h0, res_tx, 2'd0);
        rows[9]  = make_row(op_pit, ndn_pkg::kind_interest, 64'h3333_0000_0000_0003,
                            64'h0, res_tx, 2'd0);
        rows[10] = make_row(op_pit, ndn_pkg::kind_interest, 64'h4444_0000_0000_0004,
                            64'h0, res_tx, 2'd0);
        rows[11] = make_row(op_pit, ndn_pkg::kind_interest, 64'h5555_0000_0000_0005,
                            64'h0, res_tx, 2'd0);
        // Fifth insert overwrote the first prefix
        rows[12] = make_row(op_rx, ndn_pkg::kind_data, 64'h1111_0000_0000_0001,
                            64'haaaa_bbbb_cccc_dddd, res_drop, 2'd0);
        rows[13] = make_row(op_rx, ndn_pkg::kind_data, 64'h5555_0000_0000_0005,
                            64'h0f0e_0d0c_0b0a_0908, res_deliver, 2'd0);
        rows[14] = make_row(op_rx, ndn_pkg::kind_data, 64'h2222_0000_0000_0002,
                            64'h1234_5678_9abc_def0, res_deliver, 2'd0);
    endtask

    // Returns at the falling edge before the rising edge that takes the byte
    task automatic send_byte(input logic [7:0] b);
        @(negedge clk);
        rx_valid = 1'b1;
        rx_data  = b;
        while (!rx_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic send_pit(input ndn_pkg::ndn_pkt_t p);
        @(negedge clk);
        pit_in_valid = 1'b1;
        pit_in_pkt   = p;
        while (!pit_in_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        pit_in_valid = 1'b0;
        pit_in_pkt   = '0;
    endtask

    task automatic run_row(input row_t r);
        ndn_pkg::ndn_pkt_t got;
        ndn_pkg::ndn_pkt_t want;
        int                len;
        len  = wire_len(r.pkt.kind);
        want = r.pkt;
        if (r.op == op_rx) begin
            for (int j = 0; j < int'(r.junk); j++) begin
                send_byte(junk_bytes[j]);
            end
            for (int i = 0; i < len; i++) begin
                send_byte(wire_byte(r.pkt, i));
            end
            @(negedge clk);
            rx_valid = 1'b0;
            rx_data  = 8'h00;
        end else begin
            send_pit(r.pkt);
        end
        case (r.res)
            res_deliver: begin
                if (r.pkt.kind == ndn_pkg::kind_interest) begin
                    want.payload = '0;
                end
                while (pit_q.size() == 0) begin
                    @(negedge clk);
                end
                got = pit_q.pop_front();
                check_value("pit_out_pkt.kind", CMP_W'(got.kind), CMP_W'(want.kind));
                check_value("pit_out_pkt.prefix", CMP_W'(got.prefix), CMP_W'(want.prefix));
                check_value("pit_out_pkt.payload", CMP_W'(got.payload), CMP_W'(want.payload));
                check_value("drop_count", CMP_W'(drop_count), CMP_W'(drops));
            end
            res_drop: begin
                drops = drops + 8'd1;
                while (drop_count != drops) begin
                    @(negedge clk);
                end
                check_value("pit_out_valid", CMP_W'(pit_out_valid), CMP_W'(1'b0));
                check_value("pit_out transfers", CMP_W'(pit_q.size()), CMP_W'(0));
            end
            default: begin
                while (tx_q.size() < len) begin
                    @(negedge clk);
                end
                for (int i = 0; i < len; i++) begin
                    check_value($sformatf("tx_data[%0d]", i), CMP_W'(tx_q.pop_front()),
                                CMP_W'(wire_byte(r.pkt, i)));
                end
            end
        endcase
    endtask

    // Ready is updated first, so a transfer seen here is taken at the next rising edge
    always @(negedge clk) begin
        rnd           = $random(seed);
        pit_out_ready = rnd[0];
        tx_ready      = rnd[1];
        if (arst_n && pit_out_valid && pit_out_ready) begin
            pit_q.push_back(pit_out_pkt);
        end
        if (arst_n && tx_valid && tx_ready) begin
            tx_q.push_back(tx_data);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        seed          = 18553;
        arst_n        = 1'b0;
        rx_valid      = 1'b0;
        rx_data       = 8'h00;
        pit_in_valid  = 1'b0;
        pit_in_pkt    = '0;
        pit_out_ready = 1'b0;
        tx_ready      = 1'b0;
        drops         = 8'd0;
        junk_bytes[0] = 8'hff;
        junk_bytes[1] = 8'h00;
        junk_bytes[2] = 8'h71;
        load_rows();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_value("rx_ready", CMP_W'(rx_ready), CMP_W'(1'b1));
        check_value("pit_in_ready", CMP_W'(pit_in_ready), CMP_W'(1'b1));
        check_value("tx_valid", CMP_W'(tx_valid), CMP_W'(1'b0));
        check_value("pit_out_valid", CMP_W'(pit_out_valid), CMP_W'(1'b0));
        check_value("drop_count", CMP_W'(drop_count), CMP_W'(0));
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        // Nothing extra may trail the last row
        repeat (20) @(negedge clk);
        check_value("pit_out transfers", CMP_W'(pit_q.size()), CMP_W'(0));
        check_value("tx bytes", CMP_W'(tx_q.size()), CMP_W'(0));
        check_value("drop_count", CMP_W'(drop_count), CMP_W'(drops));
        $display("test passed");
        $finish;
    end

endmodule
